/* run_sim.sh */
#!/usr/bin/env bash

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sprite_engine -f tb.f \
	-o tb_sprite_engine && ./obj_dir/tb_sprite_engine > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 \
	|| grep -q "Simulation PASSED" sim.log && exit 0 \
	|| exit 1

/* sprite_engine.sv */
`timescale 1ns/1ps

module sprite_engine (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            hsync,
	input  sprite_geom_pkg::pixel_x_t       hcnt,
	input  sprite_geom_pkg::pixel_x_t       vcnt,
	input  logic [7:0]                      spriteram_data,
	input  logic [7:0]                      sprom_data,
	input  sprite_mem_pkg::colour_t         palrom_data,
	input  sprite_mem_pkg::colour_t         lb_rd_data,
	output sprite_mem_pkg::spriteram_addr_t spriteram_addr,
	output sprite_mem_pkg::sprom_addr_t     sprom_addr,
	output sprite_mem_pkg::palrom_addr_t    palrom_addr,
	output sprite_mem_pkg::lb_addr_t        lb_rd_addr,
	output sprite_mem_pkg::lb_write_t       lb_wr,
	output logic                            busy,
	output logic [7:0]                      spr_r,
	output logic [7:0]                      spr_g,
	output logic [7:0]                      spr_b,
	output logic                            spr_a
);

	sprite_mem_pkg::row_job_t job;
	logic job_start;
	logic job_done;

	sprite_table_walker walk0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.hcnt           (hcnt),
		.vcnt           (vcnt),
		.spriteram_data (spriteram_data),
		.job_done       (job_done),
		.spriteram_addr (spriteram_addr),
		.lb_rd_addr     (lb_rd_addr),
		.job            (job),
		.job_start      (job_start),
		.busy           (busy)
	);

	sprite_row_painter paint0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.job         (job),
		.job_start   (job_start),
		.sprom_data  (sprom_data),
		.palrom_data (palrom_data),
		.sprom_addr  (sprom_addr),
		.palrom_addr (palrom_addr),
		.lb_wr       (lb_wr),
		.job_done    (job_done)
	);

	// 5 to 8 bit expansion repeats the top bits so full scale stays full
	assign spr_r = {lb_rd_data[4:0], lb_rd_data[4:2]};
	assign spr_g = {lb_rd_data[9:5], lb_rd_data[9:7]};
	assign spr_b = {lb_rd_data[14:10], lb_rd_data[14:12]};
	assign spr_a = lb_rd_data[15];

endmodule

/* sprite_geom_pkg.sv */
package sprite_geom_pkg;

	// Entries in the sprite table
	localparam int SPRITE_COUNT = 32;

	// Sprites are square, this many pixels on a side
	localparam int SPRITE_SIZE = 16;

	// Last line buffer column that gets cleared for a new line
	localparam int LINE_MAX = 352;

	// Screen x plus this gives the line buffer column
	localparam int SCAN_OFFSET = 18;

	// Position of a sprite in the table
	typedef logic [4:0] sprite_index_t;

	// Column within one half of the line buffer, also used for hcnt and vcnt
	typedef logic [8:0] pixel_x_t;

	// Active line number in sprite space
	typedef logic [15:0] line_y_t;

endpackage

/* sprite_mem_model.sv */
`timescale 1ns/1ps

module sprite_mem_model (
	input  logic                            clk,
	input  sprite_mem_pkg::spriteram_addr_t spriteram_addr,
	output logic [7:0]                      spriteram_data,
	input  sprite_mem_pkg::sprom_addr_t     sprom_addr,
	output logic [7:0]                      sprom_data,
	input  sprite_mem_pkg::palrom_addr_t    palrom_addr,
	output sprite_mem_pkg::colour_t         palrom_data,
	input  sprite_mem_pkg::lb_write_t       lb_wr,
	input  sprite_mem_pkg::lb_addr_t        lb_rd_addr,
	output sprite_mem_pkg::colour_t         lb_rd_data
);

	// Table, sprite ROM and palette are loaded by the testbench at time zero
	logic [7:0] spriteram [0:127];
	logic [7:0] sprom [0:16383];
	sprite_mem_pkg::colour_t palrom [0:63];

	// Both halves of the line buffer
	sprite_mem_pkg::colour_t linebuf [0:1023];

	// One cycle registered read on every port
	always_ff @(posedge clk)
	begin
		spriteram_data <= spriteram[spriteram_addr];
		sprom_data <= sprom[sprom_addr];
		palrom_data <= palrom[palrom_addr];
	end

	// Write port from the painter, read port for scanout
	always_ff @(posedge clk)
	begin
		if (lb_wr.wr)
			linebuf[lb_wr.addr] <= lb_wr.data;
		lb_rd_data <= linebuf[lb_rd_addr];
	end

endmodule

/* sprite_mem_pkg.sv */
package sprite_mem_pkg;

	// Bytes per sprite table entry
	localparam int ENTRY_BYTES = 4;

	typedef logic [6:0] spriteram_addr_t;
	typedef logic [13:0] sprom_addr_t;
	typedef logic [5:0] palrom_addr_t;

	// Top bit picks the buffer half
	typedef logic [9:0] lb_addr_t;

	// Alpha in bit 15, then 5 bits each of blue, green and red
	typedef logic [15:0] colour_t;

	// Write port of the line buffer
	typedef struct packed {
		lb_addr_t addr;
		colour_t data;
		logic wr;
	} lb_write_t;

	// One command from the table walker to the row painter
	typedef struct packed {
		logic clear;
		logic slot;
		logic [5:0] image;
		logic [3:0] row;
		logic [9:0] x;
	} row_job_t;

endpackage

/* sprite_row_painter.sv */
`timescale 1ns/1ps

module sprite_row_painter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  sprite_mem_pkg::row_job_t     job,
	input  logic                         job_start,
	input  logic [7:0]                   sprom_data,
	input  sprite_mem_pkg::colour_t      palrom_data,
	output sprite_mem_pkg::sprom_addr_t  sprom_addr,
	output sprite_mem_pkg::palrom_addr_t palrom_addr,
	output sprite_mem_pkg::lb_write_t    lb_wr,
	output logic                         job_done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_FETCH,
		ST_PALETTE,
		ST_WRITE,
		ST_DONE
	} paint_state_t;

	paint_state_t state;
	// Set while a ROM read is still in flight
	logic rd_wait;
	logic [3:0] pixel;
	logic last_pixel;
	sprite_geom_pkg::pixel_x_t pixel_x;

	assign last_pixel = (pixel == 4'(sprite_geom_pkg::SPRITE_SIZE - 1));
	assign pixel_x = job.x[8:0] + sprite_geom_pkg::pixel_x_t'(pixel);
	assign job_done = (state == ST_DONE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			rd_wait <= 1'b0;
			pixel <= '0;
			sprom_addr <= '0;
			palrom_addr <= '0;
			lb_wr <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (job_start && job.clear)
					begin
						lb_wr.addr <= {job.slot, 9'd0};
						lb_wr.data <= '0;
						lb_wr.wr <= 1'b1;
						state <= ST_CLEAR;
					end
					else if (job_start)
					begin
						// 256 bytes per image, 16 per row
						sprom_addr <= {job.image, job.row, 4'b0000};
						pixel <= '0;
						rd_wait <= 1'b1;
						state <= ST_FETCH;
					end
				end
				ST_CLEAR:
				begin
					if (lb_wr.addr[8:0] < sprite_geom_pkg::pixel_x_t'(sprite_geom_pkg::LINE_MAX))
						lb_wr.addr <= lb_wr.addr + 1'b1;
					else
					begin
						lb_wr.wr <= 1'b0;
						state <= ST_DONE;
					end
				end
				ST_FETCH:
				begin
					if (rd_wait)
						rd_wait <= 1'b0;
					else
					begin
						// Palette entries are two bytes apart
						palrom_addr <= {sprom_data[4:0], 1'b0};
						sprom_addr <= sprom_addr + 1'b1;
						rd_wait <= 1'b1;
						state <= ST_PALETTE;
					end
				end
				ST_PALETTE:
				begin
					if (rd_wait)
						rd_wait <= 1'b0;
					else if (palrom_data[15])
					begin
						lb_wr.addr <= {job.slot, pixel_x};
						lb_wr.data <= palrom_data;
						lb_wr.wr <= 1'b1;
						state <= ST_WRITE;
					end
					else if (last_pixel)
						state <= ST_DONE;
					else
					begin
						pixel <= pixel + 1'b1;
						state <= ST_FETCH;
					end
				end
				ST_WRITE:
				begin
					lb_wr.wr <= 1'b0;
					if (last_pixel)
						state <= ST_DONE;
					else
					begin
						pixel <= pixel + 1'b1;
						state <= ST_FETCH;
					end
				end
				ST_DONE:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_IDLE |-> !lb_wr.wr)
		else $error("line buffer written while idle");

	// The walker keeps the job steady, so the slot must match it throughout
	a_write_slot: assert property (@(posedge clk) disable iff (!rst_n)
		lb_wr.wr |-> lb_wr.addr[9] == job.slot)
		else $error("write outside the job slot");

endmodule

/* sprite_table_walker.sv */
`timescale 1ns/1ps

module sprite_table_walker (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            hsync,
	input  sprite_geom_pkg::pixel_x_t       hcnt,
	input  sprite_geom_pkg::pixel_x_t       vcnt,
	input  logic [7:0]                      spriteram_data,
	input  logic                            job_done,
	output sprite_mem_pkg::spriteram_addr_t spriteram_addr,
	output sprite_mem_pkg::lb_addr_t        lb_rd_addr,
	output sprite_mem_pkg::row_job_t        job,
	output logic                            job_start,
	output logic                            busy
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_READ_Y_UPPER,
		ST_READ_Y_LOWER,
		ST_CHECK_Y,
		ST_READ_X_UPPER,
		ST_READ_X_LOWER,
		ST_DRAW,
		ST_LINE_COMPLETE
	} walk_state_t;

	walk_state_t state;
	logic hsync_q;
	logic rd_slot;
	logic wr_slot;
	// Set while a sprite RAM read is still in flight
	logic rd_wait;
	logic spr_en;
	sprite_geom_pkg::sprite_index_t spr_index;
	sprite_geom_pkg::sprite_index_t next_index;
	sprite_geom_pkg::line_y_t active_y;
	sprite_geom_pkg::line_y_t spr_y;
	sprite_mem_pkg::spriteram_addr_t next_entry_addr;
	logic hit;
	logic last_entry;

	// Enabled sprite whose 16 rows include the coming line
	assign hit = spr_en && (active_y >= spr_y) &&
		(active_y <= spr_y + sprite_geom_pkg::line_y_t'(sprite_geom_pkg::SPRITE_SIZE - 1));
	assign last_entry =
		(spr_index == sprite_geom_pkg::sprite_index_t'(sprite_geom_pkg::SPRITE_COUNT - 1));
	assign next_index = spr_index + sprite_geom_pkg::sprite_index_t'(1);
	assign next_entry_addr =
		sprite_mem_pkg::spriteram_addr_t'(next_index * sprite_mem_pkg::ENTRY_BYTES);

	assign busy = (state != ST_IDLE);

	// Scanout runs two columns ahead to cover the buffer RAM latency
	assign lb_rd_addr = {rd_slot, hcnt + sprite_geom_pkg::pixel_x_t'(sprite_geom_pkg::SPRITE_SIZE)}
		+ sprite_mem_pkg::lb_addr_t'(sprite_geom_pkg::SCAN_OFFSET - sprite_geom_pkg::SPRITE_SIZE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			hsync_q <= 1'b0;
			rd_slot <= 1'b0;
			wr_slot <= 1'b1;
			rd_wait <= 1'b0;
			spr_en <= 1'b0;
			spr_index <= '0;
			active_y <= '0;
			spr_y <= '0;
			spriteram_addr <= '0;
			job <= '0;
			job_start <= 1'b0;
		end
		else
		begin
			hsync_q <= hsync;
			job_start <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (hsync && !hsync_q)
					begin
						rd_slot <= ~rd_slot;
						wr_slot <= ~wr_slot;
						// Sprite Y is offset by one sprite height from the beam
						active_y <= sprite_geom_pkg::line_y_t'(vcnt) +
							sprite_geom_pkg::line_y_t'(sprite_geom_pkg::SPRITE_SIZE);
						// Clear the half that becomes the write half
						job.clear <= 1'b1;
						job.slot <= ~wr_slot;
						job_start <= 1'b1;
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR:
				begin
					if (job_done)
					begin
						spr_index <= '0;
						spriteram_addr <= '0;
						rd_wait <= 1'b1;
						state <= ST_READ_Y_UPPER;
					end
				end
				ST_READ_Y_UPPER:
				begin
					if (rd_wait)
						rd_wait <= 1'b0;
					else
					begin
						spr_en <= spriteram_data[7];
						spr_y[15:8] <= {4'b0000, spriteram_data[3:0]};
						spriteram_addr <= spriteram_addr + 1'b1;
						rd_wait <= 1'b1;
						state <= ST_READ_Y_LOWER;
					end
				end
				ST_READ_Y_LOWER:
				begin
					if (rd_wait)
						rd_wait <= 1'b0;
					else
					begin
						spr_y[7:0] <= spriteram_data;
						// Byte 2 is fetched while the check runs
						spriteram_addr <= spriteram_addr + 1'b1;
						state <= ST_CHECK_Y;
					end
				end
				ST_CHECK_Y:
				begin
					if (hit)
						state <= ST_READ_X_UPPER;
					else if (last_entry)
						state <= ST_LINE_COMPLETE;
					else
					begin
						spr_index <= next_index;
						spriteram_addr <= next_entry_addr;
						rd_wait <= 1'b1;
						state <= ST_READ_Y_UPPER;
					end
				end
				ST_READ_X_UPPER:
				begin
					job.image <= spriteram_data[7:2];
					job.x[9:8] <= spriteram_data[1:0];
					spriteram_addr <= spriteram_addr + 1'b1;
					rd_wait <= 1'b1;
					state <= ST_READ_X_LOWER;
				end
				ST_READ_X_LOWER:
				begin
					if (rd_wait)
						rd_wait <= 1'b0;
					else
					begin
						job.x[7:0] <= spriteram_data;
						job.clear <= 1'b0;
						job.slot <= wr_slot;
						job.row <= 4'(active_y - spr_y);
						job_start <= 1'b1;
						state <= ST_DRAW;
					end
				end
				ST_DRAW:
				begin
					if (job_done && last_entry)
						state <= ST_LINE_COMPLETE;
					else if (job_done)
					begin
						spr_index <= next_index;
						spriteram_addr <= next_entry_addr;
						rd_wait <= 1'b1;
						state <= ST_READ_Y_UPPER;
					end
				end
				ST_LINE_COMPLETE:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// The painter always gets the half that is not being scanned
	a_slots_differ: assert property (@(posedge clk) disable iff (!rst_n)
		job_start |-> job.slot != rd_slot)
		else $error("read and write slots collide");

	// No second command until the painter has answered the first
	a_one_job: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_CLEAR || state == ST_DRAW) && !job_done |=> !job_start)
		else $error("job issued while painter busy");

endmodule

/* tb.f */
sprite_geom_pkg.sv
sprite_mem_pkg.sv
sprite_row_painter.sv
sprite_table_walker.sv
sprite_engine.sv
sprite_mem_model.sv
tb_sprite_engine.sv

/* tb_sprite_engine.sv */
`timescale 1ns/1ps

module tb_sprite_engine;

	localparam int NUM_LINES = 5;
	localparam int LINE_LIMIT = 2800;
	localparam int CYCLE_LIMIT = NUM_LINES * LINE_LIMIT + 100;
	localparam int SCAN_LAST = 334;

	logic clk;
	logic rst_n;
	logic hsync;
	sprite_geom_pkg::pixel_x_t hcnt;
	sprite_geom_pkg::pixel_x_t vcnt;
	logic [7:0] spriteram_data;
	logic [7:0] sprom_data;
	sprite_mem_pkg::colour_t palrom_data;
	sprite_mem_pkg::colour_t lb_rd_data;
	sprite_mem_pkg::spriteram_addr_t spriteram_addr;
	sprite_mem_pkg::sprom_addr_t sprom_addr;
	sprite_mem_pkg::palrom_addr_t palrom_addr;
	sprite_mem_pkg::lb_addr_t lb_rd_addr;
	sprite_mem_pkg::lb_write_t lb_wr;
	logic busy;
	logic [7:0] spr_r;
	logic [7:0] spr_g;
	logic [7:0] spr_b;
	logic spr_a;

	// Reference copies of the memories
	logic [7:0] ref_spram [0:127];
	logic [7:0] ref_sprom [0:16383];
	sprite_mem_pkg::colour_t ref_pal [0:63];
	sprite_mem_pkg::colour_t ref_lb [0:1023];

	logic [31:0] lfsr_state;
	int mismatches = 0;
	int failures = 0;
	int cycles = 0;
	int line_cycles;
	int lines_started;
	logic scan_on;
	logic scan_on_q;
	logic exp_rd_slot;
	sprite_mem_pkg::lb_addr_t scan_addr_q;
	sprite_mem_pkg::lb_addr_t exp_rd_addr;

	assign exp_rd_addr = {exp_rd_slot,
		hcnt + sprite_geom_pkg::pixel_x_t'(sprite_geom_pkg::SCAN_OFFSET)};

	sprite_engine dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.hsync          (hsync),
		.hcnt           (hcnt),
		.vcnt           (vcnt),
		.spriteram_data (spriteram_data),
		.sprom_data     (sprom_data),
		.palrom_data    (palrom_data),
		.lb_rd_data     (lb_rd_data),
		.spriteram_addr (spriteram_addr),
		.sprom_addr     (sprom_addr),
		.palrom_addr    (palrom_addr),
		.lb_rd_addr     (lb_rd_addr),
		.lb_wr          (lb_wr),
		.busy           (busy),
		.spr_r          (spr_r),
		.spr_g          (spr_g),
		.spr_b          (spr_b),
		.spr_a          (spr_a)
	);

	sprite_mem_model mem0 (
		.clk            (clk),
		.spriteram_addr (spriteram_addr),
		.spriteram_data (spriteram_data),
		.sprom_addr     (sprom_addr),
		.sprom_data     (sprom_data),
		.palrom_addr    (palrom_addr),
		.palrom_data    (palrom_data),
		.lb_wr          (lb_wr),
		.lb_rd_addr     (lb_rd_addr),
		.lb_rd_data     (lb_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [15:0] next_bits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			value = {value[14:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Alpha, then red, green and blue widened to 8 bits
	function automatic logic [24:0] expand_colour(input sprite_mem_pkg::colour_t c);
		return {c[15], c[4:0], c[4:2], c[9:5], c[9:7], c[14:10], c[14:12]};
	endfunction

	task automatic set_entry(input int index, input logic en, input logic [11:0] y,
		input logic [5:0] image, input logic [9:0] x);
		ref_spram[index * sprite_mem_pkg::ENTRY_BYTES] = {en, 3'b000, y[11:8]};
		ref_spram[index * sprite_mem_pkg::ENTRY_BYTES + 1] = y[7:0];
		ref_spram[index * sprite_mem_pkg::ENTRY_BYTES + 2] = {image, x[9:8]};
		ref_spram[index * sprite_mem_pkg::ENTRY_BYTES + 3] = x[7:0];
	endtask

	task automatic fill_memories();
		for (int i = 0; i < 128; i++)
			ref_spram[i] = 8'(next_bits(8));
		// Unchosen sprites sit far below the visible lines
		for (int i = 0; i < sprite_geom_pkg::SPRITE_COUNT; i++)
			ref_spram[i * sprite_mem_pkg::ENTRY_BYTES][3:0] = 4'hf;
		for (int i = 0; i < 16384; i++)
			ref_sprom[i] = 8'(next_bits(8));
		for (int i = 0; i < 64; i++)
			ref_pal[i] = next_bits(16);
		ref_pal[0][15] = 1'b0;
		set_entry(3, 1'b1, 12'd110, 6'd5, 10'd40);
		set_entry(7, 1'b1, 12'd116, 6'd9, 10'd48);
		set_entry(12, 1'b0, 12'd108, 6'd2, 10'd44);
		set_entry(20, 1'b1, 12'd117, 6'd17, 10'd150);
		set_entry(25, 1'b1, 12'd101, 6'd63, 10'd812);
		set_entry(31, 1'b1, 12'd100, 6'd40, 10'd200);
		// Transparent pixels inside drawn rows and one with high index bits set
		ref_sprom[5 * 256 + 6 * 16 + 3] = 8'h00;
		ref_sprom[9 * 256 + 0 * 16 + 2] = 8'h20;
		for (int i = 0; i < 128; i++)
			mem0.spriteram[i] = ref_spram[i];
		for (int i = 0; i < 16384; i++)
			mem0.sprom[i] = ref_sprom[i];
		for (int i = 0; i < 64; i++)
			mem0.palrom[i] = ref_pal[i];
	endtask

	// Expected contents of one buffer half after a line
	task automatic build_reference(input sprite_geom_pkg::pixel_x_t v, input logic slot);
		sprite_geom_pkg::line_y_t active_y;
		sprite_geom_pkg::line_y_t y;
		logic [3:0] row;
		logic [5:0] image;
		logic [9:0] x;
		logic [7:0] index;
		sprite_mem_pkg::colour_t c;
		sprite_geom_pkg::pixel_x_t col;
		int base;
		active_y = sprite_geom_pkg::line_y_t'(v) + 16'(sprite_geom_pkg::SPRITE_SIZE);
		for (int a = 0; a <= sprite_geom_pkg::LINE_MAX; a++)
			ref_lb[{slot, 9'(a)}] = '0;
		// Sprites go in index order so later ones land on top
		for (int s = 0; s < sprite_geom_pkg::SPRITE_COUNT; s++)
		begin
			base = s * sprite_mem_pkg::ENTRY_BYTES;
			y = {4'h0, ref_spram[base][3:0], ref_spram[base + 1]};
			if (ref_spram[base][7] && active_y >= y && active_y <= y + 16'd15)
			begin
				row = 4'(active_y - y);
				image = ref_spram[base + 2][7:2];
				x = {ref_spram[base + 2][1:0], ref_spram[base + 3]};
				for (int p = 0; p < sprite_geom_pkg::SPRITE_SIZE; p++)
				begin
					index = ref_sprom[int'(image) * 256 + int'(row) * 16 + p];
					c = ref_pal[int'(index[4:0]) * 2];
					col = x[8:0] + 9'(p);
					if (c[15])
						ref_lb[{slot, col}] = c;
				end
			end
		end
	endtask

	task automatic run_line(input sprite_geom_pkg::pixel_x_t v);
		// The old read half becomes the write half
		build_reference(v, exp_rd_slot);
		exp_rd_slot = ~exp_rd_slot;
		lines_started++;
		vcnt = v;
		hsync = 1'b1;
		@(posedge clk);
		#1;
		hsync = 1'b0;
		@(posedge clk);
		#1;
		while (busy)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic scan_line();
		for (int h = 0; h <= SCAN_LAST; h++)
		begin
			hcnt = sprite_geom_pkg::pixel_x_t'(h);
			scan_on = 1'b1;
			@(posedge clk);
			#1;
		end
		scan_on = 1'b0;
		hcnt = '0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			line_cycles <= 0;
			scan_on_q <= 1'b0;
			scan_addr_q <= '0;
		end
		else
		begin
			line_cycles <= busy ? line_cycles + 1 : 0;
			scan_on_q <= scan_on;
			scan_addr_q <= exp_rd_addr;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			failures++;
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("Simulation FAILED");
			$finish;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		lines_started == 0 |-> !busy && !lb_wr.wr)
		else
		begin
			failures++;
			$display("Busy or line buffer write seen before the first hsync at %0t", $time);
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hsync) && !busy |=> busy)
		else
		begin
			failures++;
			$display("Busy did not rise after hsync at %0t", $time);
		end

	a_line_limit: assert property (@(posedge clk) disable iff (!rst_n)
		line_cycles < LINE_LIMIT)
		else
		begin
			failures++;
			$display("Line still busy after %0d cycles at %0t", LINE_LIMIT, $time);
		end

	a_idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !lb_wr.wr)
		else
		begin
			failures++;
			$display("Line buffer written while not busy at %0t", $time);
		end

	a_write_slot: assert property (@(posedge clk) disable iff (!rst_n)
		lb_wr.wr |-> lb_wr.addr[9] == !exp_rd_slot && lb_wr.addr[9] != lb_rd_addr[9])
		else
		begin
			mismatches++;
			$display("MISMATCH at %0t: write address %h in the wrong slot", $time, lb_wr.addr);
		end

	a_scan_addr: assert property (@(posedge clk) disable iff (!rst_n)
		scan_on |-> lb_rd_addr == exp_rd_addr)
		else
		begin
			mismatches++;
			$display("MISMATCH at %0t: read address %h, expected %h",
				$time, lb_rd_addr, exp_rd_addr);
		end

	a_scan_colour: assert property (@(posedge clk) disable iff (!rst_n)
		scan_on_q |-> {spr_a, spr_r, spr_g, spr_b} == expand_colour(ref_lb[scan_addr_q]))
		else
		begin
			mismatches++;
			$display("MISMATCH at %0t: pixel %h gives %h, expected %h", $time, scan_addr_q,
				{spr_a, spr_r, spr_g, spr_b}, expand_colour(ref_lb[scan_addr_q]));
		end

	initial
	begin
		lfsr_state = 32'h47b69434;
		rst_n = 1'b0;
		hsync = 1'b0;
		hcnt = '0;
		vcnt = '0;
		scan_on = 1'b0;
		exp_rd_slot = 1'b0;
		lines_started = 0;
		fill_memories();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		// Line 300 has no hits so its scan is pure background
		run_line(9'd300);
		run_line(9'd100);
		scan_line();
		run_line(9'd107);
		scan_line();
		run_line(9'd300);
		scan_line();
		run_line(9'd300);
		scan_line();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
